/* files.f */
hdl/cq_cfg_pkg.sv
hdl/cq_ack_pkg.sv
hdl/cq_sort.sv
hdl/cq_fifo.sv
hdl/cq_merge.sv
hdl/cq_arb_top.sv
tb/cq_arb_tb.sv

/* Makefile */
# Verilator build and run of the completion queue testbench

SIM = obj_dir/sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module cq_arb_tb \
		-f files.f -Mdir obj_dir -o sim
	@out="$$(./$(SIM))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf obj_dir

/* tb/cq_arb_tb.sv */
// completion queue arbiter testbench
module cq_arb_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import cq_cfg_pkg::*;
  import cq_ack_pkg::*;

  localparam int qdepth      = default_qdepth;
  localparam int alt_len     = 8;           // strobes per direction in the alternation phase
  localparam int n_rand      = 3000;        // cycles of random traffic
  localparam int burst_len   = qdepth + 4;  // overruns one FIFO plus the merge register
  localparam int stim_cycles = 2 * alt_len + n_rand + 2 * burst_len + 4;

  // the top two tag bits name the producer and the rest is a running count
  localparam logic [1:0] src_bpss_rd = 2'd0;
  localparam logic [1:0] src_bpss_wr = 2'd1;
  localparam logic [1:0] src_rdma    = 2'd2;

  logic aclk = 1'b0;
  logic aresetn;
  logic bpss_rd_valid;
  ack_t bpss_rd_data;
  logic bpss_wr_valid;
  ack_t bpss_wr_data;
  logic rdma_valid;
  ack_t rdma_data;
  logic cq_rd_valid;
  ack_t cq_rd_data;
  logic cq_rd_ready;
  logic cq_wr_valid;
  ack_t cq_wr_data;
  logic cq_wr_ready;
  logic overflow [n_queues];

  ack_t        fifo_q [n_queues][$];  // expected FIFO contents including the head register
  logic        exp_ovf [n_queues];
  logic        prev_valid [2];        // output state of each direction seen one negedge earlier
  logic        prev_ready [2];
  ack_t        prev_data [2];
  logic        pend_v [3];            // producer inputs waiting for the next rising edge
  ack_t        pend_d [3];
  int          n_alt [2];
  logic        model_on;
  logic        alt_on;                // outputs must alternate RDMA and bypass
  logic [13:0] seq [4];
  logic [31:0] rng_state;
  int          err_value;
  int          err_other;
  int          n_checked;

  always #5 aclk = ~aclk;

  cq_arb_top #(.qdepth(qdepth)) cq_arb_top_inst (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .bpss_rd_valid (bpss_rd_valid),
    .bpss_rd_data  (bpss_rd_data),
    .bpss_wr_valid (bpss_wr_valid),
    .bpss_wr_data  (bpss_wr_data),
    .rdma_valid    (rdma_valid),
    .rdma_data     (rdma_data),
    .cq_rd_valid   (cq_rd_valid),
    .cq_rd_data    (cq_rd_data),
    .cq_rd_ready   (cq_rd_ready),
    .cq_wr_valid   (cq_wr_valid),
    .cq_wr_data    (cq_wr_data),
    .cq_wr_ready   (cq_wr_ready),
    .overflow      (overflow)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // mostly read responses and acks with some opcodes the sorter has to drop
  function automatic opcode_t random_opcode(input logic [31:0] r);
    case (r[14:12])
      3'd0:       return op_rd_resp_first;
      3'd1:       return op_rd_resp_middle;
      3'd2:       return op_rd_resp_last;
      3'd3:       return op_rd_resp_only;
      3'd4, 3'd5: return op_ack;
      default:    return opcode_t'(r[31:27]);  // any value whether supported or not
    endcase
  endfunction

  function automatic ack_t make_entry(input logic [1:0] src, input opcode_t op);
    ack_t        e;
    logic [31:0] r;
    r        = next_random();
    e.opcode = op;
    e.qpn    = r[9:0];
    e.tag    = {src, seq[src]};
    seq[src] = seq[src] + 14'd1;
    return e;
  endfunction

  // FIFO slot an entry belongs in or -1 when it must never reach a FIFO
  function automatic int queue_for(input ack_t e);
    case (e.tag[15:14])
      src_bpss_rd: return q_bpss_rd;
      src_bpss_wr: return q_bpss_wr;
      src_rdma: begin
        if (e.opcode inside {op_rd_resp_first, op_rd_resp_middle,
                             op_rd_resp_last, op_rd_resp_only})
          return q_rdma_rd;
        if (e.opcode == op_ack)
          return q_rdma_wr;
        return -1;
      end
      default: return -1;
    endcase
  endfunction

  function automatic string dir_name(input int d);
    return (d == 0) ? "cq_rd" : "cq_wr";
  endfunction

  function automatic logic model_idle();
    logic idle;
    idle = !cq_rd_valid && !cq_wr_valid;
    for (int i = 0; i < n_queues; i++)
      if (fifo_q[i].size() != 0)
        idle = 1'b0;
    return idle;
  endfunction

  // replays the rising edge that lies between this negedge and the previous one
  task automatic step_model();
    logic v [2];
    logic rdy [2];
    ack_t x [2];
    int   pre_cnt [n_queues];
    logic pop_q [n_queues];
    int   d;
    int   i;
    int   q;
    int   exp_q;
    v[0] = cq_rd_valid;
    v[1] = cq_wr_valid;
    rdy[0] = cq_rd_ready;
    rdy[1] = cq_wr_ready;
    x[0] = cq_rd_data;
    x[1] = cq_wr_data;
    for (i = 0; i < n_queues; i++) begin
      pre_cnt[i] = fifo_q[i].size();  // the full test uses the count before this edge
      pop_q[i]   = 1'b0;
    end
    for (d = 0; d < 2; d++) begin
      if (prev_valid[d] && !prev_ready[d]) begin
        // valid and data of a stalled output must not move
        if (v[d] !== 1'b1) begin
          $display("ERR %s_valid got %h exp %h", dir_name(d), v[d], 1'b1);
          err_value++;
        end else if (x[d] !== prev_data[d]) begin
          $display("ERR %s_data got %h exp %h", dir_name(d), x[d], prev_data[d]);
          err_value++;
        end
      end else if (v[d]) begin
        q = queue_for(x[d]);  // a fresh entry was loaded on the last edge
        if (q < 0) begin
          $display("%s carried tag %h with opcode %h that no FIFO may hold",
                   dir_name(d), x[d].tag, x[d].opcode);
          err_other++;
        end else if ((q == q_bpss_rd || q == q_rdma_rd) != (d == 0)) begin
          $display("%s carried tag %h that belongs to the other direction",
                   dir_name(d), x[d].tag);
          err_other++;
        end else if (fifo_q[q].size() == 0) begin
          $display("%s carried tag %h but FIFO %0d was expected to be empty",
                   dir_name(d), x[d].tag, q);
          err_other++;
        end else begin
          n_checked++;
          if (x[d] !== fifo_q[q][0]) begin
            $display("ERR %s_data got %h exp %h", dir_name(d), x[d], fifo_q[q][0]);
            err_value++;
          end
          if (alt_on && n_alt[d] < 2 * alt_len) begin
            // even loads come from RDMA since rr starts at 0
            if (n_alt[d] % 2 == 0)
              exp_q = (d == 0) ? q_rdma_rd : q_rdma_wr;
            else
              exp_q = (d == 0) ? q_bpss_rd : q_bpss_wr;
            if (q != exp_q) begin
              $display("%s load %0d came from FIFO %0d instead of FIFO %0d",
                       dir_name(d), n_alt[d], q, exp_q);
              err_other++;
            end
            n_alt[d]++;
          end
          pop_q[q] = 1'b1;
          void'(fifo_q[q].pop_front());
        end
      end
      prev_valid[d] = v[d];
      prev_ready[d] = rdy[d];
      prev_data[d]  = x[d];
    end
    for (i = 0; i < 3; i++) begin
      if (pend_v[i]) begin
        q = queue_for(pend_d[i]);
        if (q >= 0) begin
          if (pre_cnt[q] < qdepth || pop_q[q])  // a pop frees room on the same edge
            fifo_q[q].push_back(pend_d[i]);
          else
            exp_ovf[q] = 1'b1;
        end
      end
    end
    for (i = 0; i < n_queues; i++) begin
      if (overflow[i] !== exp_ovf[i]) begin
        $display("ERR overflow[%0d] got %h exp %h", i, overflow[i], exp_ovf[i]);
        err_value++;
      end
    end
    pend_v[0] = bpss_rd_valid;
    pend_d[0] = bpss_rd_data;
    pend_v[1] = bpss_wr_valid;
    pend_d[1] = bpss_wr_data;
    pend_v[2] = rdma_valid;
    pend_d[2] = rdma_data;
  endtask

  always @(negedge aclk) begin
    if (model_on)
      step_model();
  end

  task automatic next_edge();
    @(posedge aclk);
    #1;  // inputs change away from the sampling edge
  endtask

  task automatic clear_strobes();
    bpss_rd_valid = 1'b0;
    bpss_wr_valid = 1'b0;
    rdma_valid    = 1'b0;
  endtask

  // ready high and no new entries until the model and both outputs are empty
  task automatic drain_all();
    next_edge();
    clear_strobes();
    cq_rd_ready = 1'b1;
    cq_wr_ready = 1'b1;
    do begin
      @(negedge aclk);
      #1;
    end while (!model_idle());
  endtask

  // one strobe into idle queues shows up on the output after the second edge
  task automatic probe_latency(input logic to_wr);
    logic seen;
    next_edge();
    if (to_wr) begin
      bpss_wr_valid = 1'b1;
      bpss_wr_data  = make_entry(src_bpss_wr, 5'h00);
    end else begin
      rdma_valid = 1'b1;
      rdma_data  = make_entry(src_rdma, op_rd_resp_only);
    end
    next_edge();  // the strobe is sampled on this edge
    clear_strobes();
    @(negedge aclk);
    seen = to_wr ? cq_wr_valid : cq_rd_valid;
    if (seen) begin
      $display("%s showed the strobe after one cycle instead of two", dir_name(int'(to_wr)));
      err_other++;
    end
    @(negedge aclk);
    seen = to_wr ? cq_wr_valid : cq_rd_valid;
    if (!seen) begin
      $display("%s did not show the strobe two cycles after it was sampled",
               dir_name(int'(to_wr)));
      err_other++;
    end
  endtask

  initial begin : watchdog
    repeat (stim_cycles * 20 + 1000) @(posedge aclk);
    $display("timeout: the run did not finish within %0d cycles", stim_cycles * 20 + 1000);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int          i;
    logic [31:0] r;
    logic        slow;
    logic        ovf_exp;
    aresetn = 1'b0;
    clear_strobes();
    bpss_rd_data = '0;
    bpss_wr_data = '0;
    rdma_data    = '0;
    cq_rd_ready  = 1'b0;
    cq_wr_ready  = 1'b0;
    rng_state    = 32'hb4bc_177e;
    model_on     = 1'b0;
    alt_on       = 1'b1;
    err_value    = 0;
    err_other    = 0;
    n_checked    = 0;
    for (i = 0; i < n_queues; i++)
      exp_ovf[i] = 1'b0;
    for (i = 0; i < 4; i++)
      seq[i] = '0;
    for (i = 0; i < 3; i++) begin
      pend_v[i] = 1'b0;
      pend_d[i] = '0;
    end
    for (i = 0; i < 2; i++) begin
      prev_valid[i] = 1'b0;
      prev_ready[i] = 1'b0;
      prev_data[i]  = '0;
      n_alt[i]      = 0;
    end
    repeat (4) @(posedge aclk);
    #1;
    aresetn  = 1'b1;
    model_on = 1'b1;
    @(negedge aclk);
    if (cq_rd_valid !== 1'b0 || cq_wr_valid !== 1'b0) begin
      $display("ERR cq_rd_valid/cq_wr_valid got %h/%h exp 0/0", cq_rd_valid, cq_wr_valid);
      err_value++;
    end

    // both sources of a direction fill up behind a stalled output and then drain in turns
    for (i = 0; i < 2 * alt_len; i++) begin
      next_edge();
      clear_strobes();
      if (i % 2 == 0) begin
        bpss_rd_valid = 1'b1;
        bpss_rd_data  = make_entry(src_bpss_rd, 5'h00);
        rdma_valid    = 1'b1;
        rdma_data     = make_entry(src_rdma, op_rd_resp_middle);
      end else begin
        bpss_wr_valid = 1'b1;
        bpss_wr_data  = make_entry(src_bpss_wr, 5'h00);
        rdma_valid    = 1'b1;
        rdma_data     = make_entry(src_rdma, op_ack);
      end
    end
    next_edge();
    clear_strobes();
    repeat (3) next_edge();
    drain_all();
    alt_on = 1'b0;

    // with both outputs stalled one FIFO at a time gets more than it can hold
    for (i = 0; i < burst_len; i++) begin
      next_edge();
      cq_rd_ready   = 1'b0;
      cq_wr_ready   = 1'b0;
      bpss_rd_valid = 1'b1;
      bpss_rd_data  = make_entry(src_bpss_rd, 5'h00);
    end
    next_edge();
    clear_strobes();
    for (i = 0; i < burst_len; i++) begin
      next_edge();
      rdma_valid = 1'b1;
      rdma_data  = make_entry(src_rdma, op_ack);
    end
    next_edge();
    clear_strobes();
    @(negedge aclk);
    #1;
    // only the two overrun FIFOs may have flagged an overflow so far
    for (i = 0; i < n_queues; i++) begin
      ovf_exp = (i == q_bpss_rd) || (i == q_rdma_wr);
      if (overflow[i] !== ovf_exp) begin
        $display("ERR overflow[%0d] got %h exp %h", i, overflow[i], ovf_exp);
        err_value++;
      end
    end
    drain_all();

    for (i = 0; i < n_rand; i++) begin
      next_edge();
      r = next_random();
      clear_strobes();
      if (r[4:3] == 2'd0) begin
        bpss_rd_valid = 1'b1;
        bpss_rd_data  = make_entry(src_bpss_rd, opcode_t'(r[20:16]));
      end
      if (r[6:5] == 2'd0) begin
        bpss_wr_valid = 1'b1;
        bpss_wr_data  = make_entry(src_bpss_wr, opcode_t'(r[25:21]));
      end
      if (r[7]) begin
        rdma_valid = 1'b1;
        rdma_data  = make_entry(src_rdma, random_opcode(r));
      end
      slow = ((i / 256) % 2 == 1);  // stretches of heavy back-pressure fill the FIFOs
      cq_rd_ready = slow ? (r[9:8] == 2'd0) : (r[9:8] != 2'd0);
      cq_wr_ready = slow ? (r[11:10] == 2'd0) : (r[11:10] != 2'd0);
    end
    drain_all();

    probe_latency(1'b0);
    drain_all();
    probe_latency(1'b1);
    drain_all();

    repeat (5) next_edge();  // nothing may show up once everything is drained
    @(negedge aclk);
    #1;
    if (!model_idle()) begin
      $display("entries were left over after the final drain");
      err_other++;
    end

    $display("summary: %0d entries checked, %0d value errors, %0d other errors",
             n_checked, err_value, err_other);
    if (err_value == 0 && err_other == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* hdl/cq_arb_top.sv */
// completion queue arbiter top
module cq_arb_top #(
  parameter int qdepth = cq_cfg_pkg::default_qdepth
) (
  input  logic             aclk,
  input  logic             aresetn,
  // producers, strobes without back-pressure
  input  logic             bpss_rd_valid,
  input  cq_ack_pkg::ack_t bpss_rd_data,
  input  logic             bpss_wr_valid,
  input  cq_ack_pkg::ack_t bpss_wr_data,
  input  logic             rdma_valid,
  input  cq_ack_pkg::ack_t rdma_data,
  // ordered completion streams
  output logic             cq_rd_valid,
  output cq_ack_pkg::ack_t cq_rd_data,
  input  logic             cq_rd_ready,
  output logic             cq_wr_valid,
  output cq_ack_pkg::ack_t cq_wr_data,
  input  logic             cq_wr_ready,
  // sticky per FIFO, cleared by reset only
  output logic             overflow [cq_cfg_pkg::n_queues]
);

  import cq_cfg_pkg::*;
  import cq_ack_pkg::*;

  logic wr_en   [n_queues];  // sorter to FIFOs, combinational
  ack_t wr_data [n_queues];
  logic q_valid [n_queues];  // FIFO heads towards the merge
  ack_t q_data  [n_queues];
  logic q_ready [n_queues];

  // classify the three producers into four write ports
  cq_sort u_sort (
    .bpss_rd_valid (bpss_rd_valid),
    .bpss_rd_data  (bpss_rd_data),
    .bpss_wr_valid (bpss_wr_valid),
    .bpss_wr_data  (bpss_wr_data),
    .rdma_valid    (rdma_valid),
    .rdma_data     (rdma_data),
    .wr_en         (wr_en),
    .wr_data       (wr_data)
  );

  // one FIFO per slot, slot numbers come from the config package
  for (genvar i = 0; i < n_queues; i++) begin : g_q
    cq_fifo #(
      .qdepth  (qdepth),
      .entry_t (ack_t)
    ) u_fifo (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .wr_en    (wr_en[i]),
      .wr_data  (wr_data[i]),
      .q_valid  (q_valid[i]),
      .q_data   (q_data[i]),
      .q_ready  (q_ready[i]),
      .overflow (overflow[i])
    );
  end

  // read and write arbiters with registered outputs
  cq_merge u_merge (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .q_valid     (q_valid),
    .q_data      (q_data),
    .q_ready     (q_ready),
    .cq_rd_valid (cq_rd_valid),
    .cq_rd_data  (cq_rd_data),
    .cq_rd_ready (cq_rd_ready),
    .cq_wr_valid (cq_wr_valid),
    .cq_wr_data  (cq_wr_data),
    .cq_wr_ready (cq_wr_ready)
  );

endmodule

/* hdl/cq_merge.sv */
// round-robin completion merge
module cq_merge (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             q_valid [cq_cfg_pkg::n_queues],
  input  cq_ack_pkg::ack_t q_data  [cq_cfg_pkg::n_queues],
  output logic             q_ready [cq_cfg_pkg::n_queues],
  output logic             cq_rd_valid,
  output cq_ack_pkg::ack_t cq_rd_data,
  input  logic             cq_rd_ready,
  output logic             cq_wr_valid,
  output cq_ack_pkg::ack_t cq_wr_data,
  input  logic             cq_wr_ready
);

  import cq_cfg_pkg::*;
  import cq_ack_pkg::*;

  localparam int n_dirs = 2;
  localparam int dir_rd = 0;
  localparam int dir_wr = 1;

  // both directions share the same arbiter code, indexed by direction
  logic out_valid [n_dirs];
  ack_t out_data  [n_dirs];
  logic out_ready [n_dirs];

  assign cq_rd_valid       = out_valid[dir_rd];
  assign cq_rd_data        = out_data[dir_rd];
  assign out_ready[dir_rd] = cq_rd_ready;

  assign cq_wr_valid       = out_valid[dir_wr];
  assign cq_wr_data        = out_data[dir_wr];
  assign out_ready[dir_wr] = cq_wr_ready;

  for (genvar d = 0; d < n_dirs; d++) begin : g_dir
    // the two FIFOs competing for this direction
    localparam int bpss_idx = (d == dir_rd) ? q_bpss_rd : q_bpss_wr;
    localparam int rdma_idx = (d == dir_rd) ? q_rdma_rd : q_rdma_wr;

    logic rr;         // 0 prefers RDMA, 1 prefers bypass
    logic can_load;   // output register empty or emptied this cycle
    logic pick_rdma;
    logic pick_bpss;
    logic take;       // an entry moves from a FIFO into the register

    assign can_load = ~out_valid[d] | out_ready[d];

    // preferred source first, the other one only when the preferred is empty
    always_comb begin
      if (rr) begin
        pick_bpss = q_valid[bpss_idx];
        pick_rdma = q_valid[rdma_idx] & ~q_valid[bpss_idx];
      end else begin
        pick_rdma = q_valid[rdma_idx];
        pick_bpss = q_valid[bpss_idx] & ~q_valid[rdma_idx];
      end
    end

    assign take              = can_load & (pick_rdma | pick_bpss);
    assign q_ready[rdma_idx] = can_load & pick_rdma;  // grant doubles as the FIFO pop
    assign q_ready[bpss_idx] = can_load & pick_bpss;

    always_ff @(posedge aclk) begin
      if (!aresetn) begin
        rr           <= 1'b0;  // first grant after reset goes to RDMA
        out_valid[d] <= 1'b0;
      end else begin
        if (can_load)
          out_valid[d] <= take;  // held while the consumer stalls
        if (take)
          rr <= ~rr;  // flip on every load so the other source goes next
      end
    end

    always_ff @(posedge aclk) begin
      if (take)
        out_data[d] <= pick_rdma ? q_data[rdma_idx] : q_data[bpss_idx];
    end
  end

endmodule

/* hdl/cq_fifo.sv */
// completion FIFO
module cq_fifo #(
  parameter int  qdepth  = cq_cfg_pkg::default_qdepth,
  parameter type entry_t = cq_ack_pkg::ack_t
) (
  input  logic   aclk,
  input  logic   aresetn,
  input  logic   wr_en,
  input  entry_t wr_data,
  output logic   q_valid,
  output entry_t q_data,
  input  logic   q_ready,
  output logic   overflow
);

  localparam int ptr_w = $clog2(qdepth);      // qdepth is a power of two
  localparam int cnt_w = $clog2(qdepth + 1);  // count goes up to qdepth itself

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [cnt_w-1:0] cnt_t;

  entry_t mem [qdepth];  // backing store behind the output register
  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  cnt_t   count;         // stored entries plus the one in the output register

  logic pop;       // head leaves this cycle
  logic full;
  logic accept;    // write is taken, either into mem or straight to the head
  logic out_load;  // output register is free or being drained
  logic buf_empty;

  assign pop       = q_valid & q_ready;
  assign full      = (count == cnt_t'(qdepth));
  assign accept    = wr_en & (~full | pop);  // a read frees a slot in the same cycle
  assign out_load  = ~q_valid | pop;
  // the head register fills first, so mem never reaches qdepth entries and
  // equal pointers always mean an empty store
  assign buf_empty = (wr_ptr == rd_ptr);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      q_valid  <= 1'b0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // full and not draining, the new entry is lost and this is remembered
      if (wr_en && !accept)
        overflow <= 1'b1;

      case ({accept, pop})
        2'b10:   count <= count + cnt_t'(1);
        2'b01:   count <= count - cnt_t'(1);
        default: count <= count;  // idle, or one in and one out
      endcase

      if (out_load) begin
        if (!buf_empty) begin
          rd_ptr  <= rd_ptr + ptr_t'(1);  // oldest stored entry moves to the head
          q_valid <= 1'b1;
        end else begin
          q_valid <= accept;  // empty store, a new write bypasses it
        end
      end

      // a write goes to mem unless it took the bypass into the head register
      if (accept && !(out_load && buf_empty))
        wr_ptr <= wr_ptr + ptr_t'(1);
    end
  end

  // payload path without reset
  always_ff @(posedge aclk) begin
    if (out_load) begin
      if (!buf_empty)
        q_data <= mem[rd_ptr];
      else if (accept)
        q_data <= wr_data;
    end
    if (accept && !(out_load && buf_empty))
      mem[wr_ptr] <= wr_data;
  end

endmodule

/* hdl/cq_sort.sv */
// completion classifier
module cq_sort (
  input  logic               bpss_rd_valid,
  input  cq_ack_pkg::ack_t   bpss_rd_data,
  input  logic               bpss_wr_valid,
  input  cq_ack_pkg::ack_t   bpss_wr_data,
  input  logic               rdma_valid,
  input  cq_ack_pkg::ack_t   rdma_data,
  output logic               wr_en   [cq_cfg_pkg::n_queues],
  output cq_ack_pkg::ack_t   wr_data [cq_cfg_pkg::n_queues]
);

  import cq_cfg_pkg::*;
  import cq_ack_pkg::*;

  logic rdma_is_rd;  // opcode is one of the read response segments
  logic rdma_is_wr;  // opcode is a plain acknowledge

  // the opcode decides the direction, everything else is dropped here
  assign rdma_is_rd = is_opcode_rd_resp(rdma_data.opcode);
  assign rdma_is_wr = is_opcode_ack(rdma_data.opcode);

  always_comb begin
    // bypass producers already know their direction
    wr_en[q_bpss_rd]   = bpss_rd_valid;
    wr_data[q_bpss_rd] = bpss_rd_data;
    wr_en[q_bpss_wr]   = bpss_wr_valid;
    wr_data[q_bpss_wr] = bpss_wr_data;

    // the single RDMA stream fans out to both RDMA FIFOs
    // at most one of the two enables can be high for a given opcode
    wr_en[q_rdma_rd]   = rdma_valid & rdma_is_rd;
    wr_data[q_rdma_rd] = rdma_data;
    wr_en[q_rdma_wr]   = rdma_valid & rdma_is_wr;  // unsupported opcodes raise neither
    wr_data[q_rdma_wr] = rdma_data;
  end

endmodule

/* hdl/cq_ack_pkg.sv */
// completion entry definitions
package cq_ack_pkg;

  typedef logic [4:0] opcode_t;

  // one completion as reported by a producer, 31 bits in total
  typedef struct packed {
    opcode_t     opcode;  // transport opcode, only meaningful for RDMA entries
    logic [9:0]  qpn;     // queue pair the completion belongs to
    logic [15:0] tag;     // request identifier handed back to the host
  } ack_t;

  // RDMA read response opcodes, RC transport encoding
  localparam opcode_t op_rd_resp_first  = 5'h0d;
  localparam opcode_t op_rd_resp_middle = 5'h0e;
  localparam opcode_t op_rd_resp_last   = 5'h0f;
  localparam opcode_t op_rd_resp_only   = 5'h10;

  // plain acknowledge, closes a write on the RDMA side
  localparam opcode_t op_ack = 5'h11;

  // any segment of a read response counts as a read completion
  function automatic logic is_opcode_rd_resp(input opcode_t opcode);
    logic hit;
    hit = (opcode == op_rd_resp_first)  ||
          (opcode == op_rd_resp_middle) ||
          (opcode == op_rd_resp_last)   ||
          (opcode == op_rd_resp_only);
    return hit;
  endfunction

  // write completions from RDMA arrive only as acknowledges
  function automatic logic is_opcode_ack(input opcode_t opcode);
    return opcode == op_ack;
  endfunction

endpackage

/* hdl/cq_cfg_pkg.sv */
// completion queue configuration
package cq_cfg_pkg;

  // one FIFO per source and direction
  localparam int n_queues = 4;

  // slot numbers of the completion FIFOs, also the generate index at the top
  localparam int q_bpss_rd = 0;  // bypass read completions
  localparam int q_bpss_wr = 1;  // bypass write completions
  localparam int q_rdma_rd = 2;  // RDMA read responses
  localparam int q_rdma_wr = 3;  // RDMA acknowledges

  // entries held per FIFO, the output register counts as one of them
  // must stay a power of two of at least 2
  localparam int default_qdepth = 16;

endpackage
